// File: verilog/spi_bridge_pkg.sv
package spi_bridge_pkg;

  // data byte on every path between the blocks
  typedef logic [7:0] byte_t;

  // command opcode as sent by the ESP
  typedef logic [7:0] opcode_t;

  // parser states
  typedef enum logic [1:0] {
    idle,
    read_bytes
  } parser_state_t;

  // parameter bytes still to come
  typedef logic [2:0] param_count_t;

  // bit position inside an SPI byte
  typedef logic [2:0] bit_count_t;

  // opcode values, kept compatible with the ESP firmware
  localparam opcode_t op_get_cookie       = 8'd0;
  localparam opcode_t op_get_version      = 8'd15;
  localparam opcode_t op_set_led          = 8'd26;
  localparam opcode_t op_get_config       = 8'd27;
  localparam opcode_t op_set_spi_ctrl_reg = 8'd29;
  localparam opcode_t op_set_spi_data     = 8'd30;
  localparam opcode_t op_get_spi_data     = 8'd31;

  // true for every opcode the bridge decodes
  function automatic logic opcode_known(opcode_t op);
    case (op)
      op_get_cookie, op_get_version, op_set_led, op_get_config,
      op_set_spi_ctrl_reg, op_set_spi_data, op_get_spi_data: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // number of parameter bytes that follow the opcode
  function automatic param_count_t opcode_params(opcode_t op);
    case (op)
      op_set_led:          return 3'd1;
      op_set_spi_ctrl_reg: return 3'd1;
      op_set_spi_data:     return 3'd1;
      default:             return 3'd0;
    endcase
  endfunction

endpackage

// File: verilog/spi_slave.sv
`timescale 1ns/1ps

module spi_slave import spi_bridge_pkg::*; (
  input  logic  clk,
  input  logic  cass_out_sel_n,
  input  logic  sck,
  input  logic  cs_n,
  input  logic  mosi,
  input  byte_t byte_out,
  output logic  miso,
  output byte_t byte_in,
  output logic  byte_received
);

  logic [2:0] sck_r;
  logic [2:0] cs_r;
  logic [1:0] mosi_r;
  bit_count_t bit_cnt;
  byte_t      tx_shift;
  logic       load_pending;

  // pin synchronizers, cs idles high out of reset
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_r  <= 3'b000;
      cs_r   <= 3'b111;
      mosi_r <= 2'b00;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs_n};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  wire sck_rise  = (sck_r[2:1] == 2'b01);
  wire sck_fall  = (sck_r[2:1] == 2'b10);
  wire cs_active = ~cs_r[1];
  // chip select just went active
  wire cs_start  = cs_r[2] & ~cs_r[1];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt       <= '0;
      byte_in       <= '0;
      byte_received <= 1'b0;
      tx_shift      <= '0;
      load_pending  <= 1'b0;
    end else begin
      byte_received <= 1'b0;
      if (cs_start)
        load_pending <= 1'b1;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          byte_in <= {byte_in[6:0], mosi_r[1]};
          if (bit_cnt == 3'd7) begin
            byte_received <= 1'b1;
            load_pending  <= 1'b1;
          end
        end
        // response byte goes out MSB first
        if (sck_fall) begin
          if (load_pending) begin
            tx_shift     <= byte_out;
            load_pending <= 1'b0;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  // held low while deselected
  assign miso = cs_active & tx_shift[7];

endmodule

// File: verilog/cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser import spi_bridge_pkg::*; (
  input  logic    clk,
  input  logic    cass_out_sel_n,
  input  byte_t   byte_in,
  input  logic    byte_received,
  output logic    action,
  output opcode_t cmd,
  output byte_t   arg,
  output logic    unknown_cmd
);

  parser_state_t state;
  param_count_t  bytes_to_read;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state         <= idle;
      bytes_to_read <= '0;
      cmd           <= op_get_cookie;
      arg           <= '0;
      action        <= 1'b0;
      unknown_cmd   <= 1'b0;
    end else begin
      // both strobes last a single cycle
      action      <= 1'b0;
      unknown_cmd <= 1'b0;

      if (byte_received) begin
        case (state)
          idle: begin
            cmd <= byte_in;
            if (!opcode_known(byte_in)) begin
              // stay in idle, next byte is taken as an opcode
              unknown_cmd <= 1'b1;
            end else if (opcode_params(byte_in) == 3'd0) begin
              action <= 1'b1;
            end else begin
              bytes_to_read <= opcode_params(byte_in);
              state         <= read_bytes;
            end
          end

          read_bytes: begin
            arg <= byte_in;
            if (bytes_to_read == 3'd1) begin
              // last parameter completes the command
              action <= 1'b1;
              state  <= idle;
            end else begin
              bytes_to_read <= bytes_to_read - 3'd1;
            end
          end

          default: begin
            state <= idle;
          end
        endcase
      end
    end
  end

endmodule

// File: verilog/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs import spi_bridge_pkg::*; #(
  parameter byte_t      COOKIE        = 8'haf,
  parameter logic [2:0] VERSION_MAJOR = 3'd0,
  parameter logic [4:0] VERSION_MINOR = 5'd3
) (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       action,
  input  opcode_t    cmd,
  input  byte_t      arg,
  input  logic       unknown_cmd,
  input  logic [3:0] conf,
  input  byte_t      spi_data,
  output byte_t      byte_out,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic       led_err
);

  // rgb status leds
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red   <= 1'b0;
      led_green <= 1'b0;
      led_blue  <= 1'b0;
    end else if (action && cmd == op_set_led) begin
      led_red   <= arg[0];
      led_green <= arg[1];
      led_blue  <= arg[2];
    end
  end

  // sticky until the next reset
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n)
      led_err <= 1'b0;
    else if (unknown_cmd)
      led_err <= 1'b1;
  end

  // readback, shifted out during the following SPI byte
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      byte_out <= '0;
    end else if (action) begin
      case (cmd)
        op_get_cookie:   byte_out <= COOKIE;
        op_get_version:  byte_out <= {VERSION_MAJOR, VERSION_MINOR};
        // dip switches read active low
        op_get_config:   byte_out <= {4'b0000, ~conf};
        op_get_spi_data: byte_out <= spi_data;
        default:         byte_out <= byte_out;
      endcase
    end
  end

endmodule

// File: verilog/flash_spi_master.sv
`timescale 1ns/1ps

module flash_spi_master import spi_bridge_pkg::*; #(
  parameter int FLASH_HALF_LOG2 = 3
) (
  input  logic    clk,
  input  logic    cass_out_sel_n,
  input  logic    action,
  input  opcode_t cmd,
  input  byte_t   arg,
  input  logic    flash_so,
  output byte_t   spi_data,
  output logic    flash_cs_n,
  output logic    flash_clk,
  output logic    flash_si
);

  // prescale bits, clock bit, 3 bit index bits and the busy bit on top
  localparam int CNT_W = FLASH_HALF_LOG2 + 5;

  logic             ctrl_sel;
  logic [CNT_W-1:0] counter;
  byte_t            shift_reg;
  logic             sdo;

  wire busy       = counter[CNT_W-1];
  wire half_start = (counter[FLASH_HALF_LOG2-1:0] == '0);

  // control register, only bit 7 (flash select) is wired
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n)
      ctrl_sel <= 1'b0;
    else if (action && cmd == op_set_spi_ctrl_reg)
      ctrl_sel <= arg[7];
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      counter   <= '0;
      shift_reg <= '0;
      sdo       <= 1'b0;
    end else if (busy) begin
      // wraps to zero after the eighth clock, which ends the transfer
      counter <= counter + 1'b1;
      if (half_start) begin
        if (!counter[FLASH_HALF_LOG2])
          sdo <= shift_reg[7];
        else
          shift_reg <= {shift_reg[6:0], flash_so};
      end
    end else if (action && cmd == op_set_spi_data) begin
      shift_reg <= arg;
      counter   <= {1'b1, {(CNT_W-1){1'b0}}};
    end
  end

  assign spi_data   = shift_reg;
  assign flash_cs_n = ~ctrl_sel;
  assign flash_clk  = counter[FLASH_HALF_LOG2];
  assign flash_si   = sdo;

endmodule

// File: verilog/spi_bridge_top.sv
`timescale 1ns/1ps

module spi_bridge_top import spi_bridge_pkg::*; #(
  parameter byte_t      COOKIE          = 8'haf,
  parameter logic [2:0] VERSION_MAJOR   = 3'd0,
  parameter logic [4:0] VERSION_MINOR   = 5'd3,
  parameter int         FLASH_HALF_LOG2 = 3
) (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic [3:0] conf,
  input  logic       flash_so,
  output logic       miso,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic       led_err,
  output logic       flash_cs_n,
  output logic       flash_clk,
  output logic       flash_si
);

  byte_t   byte_in;
  byte_t   byte_out;
  logic    byte_received;
  logic    action;
  opcode_t cmd;
  byte_t   arg;
  logic    unknown_cmd;
  byte_t   spi_data;

  // ESP facing slave port
  spi_slave u_spi_slave (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .byte_out       (byte_out),
    .miso           (miso),
    .byte_in        (byte_in),
    .byte_received  (byte_received)
  );

  cmd_parser u_cmd_parser (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .byte_in        (byte_in),
    .byte_received  (byte_received),
    .action         (action),
    .cmd            (cmd),
    .arg            (arg),
    .unknown_cmd    (unknown_cmd)
  );

  ctrl_regs #(
    .COOKIE        (COOKIE),
    .VERSION_MAJOR (VERSION_MAJOR),
    .VERSION_MINOR (VERSION_MINOR)
  ) u_ctrl_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .action         (action),
    .cmd            (cmd),
    .arg            (arg),
    .unknown_cmd    (unknown_cmd),
    .conf           (conf),
    .spi_data       (spi_data),
    .byte_out       (byte_out),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .led_err        (led_err)
  );

  // configuration flash port
  flash_spi_master #(
    .FLASH_HALF_LOG2 (FLASH_HALF_LOG2)
  ) u_flash_spi_master (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .action         (action),
    .cmd            (cmd),
    .arg            (arg),
    .flash_so       (flash_so),
    .spi_data       (spi_data),
    .flash_cs_n     (flash_cs_n),
    .flash_clk      (flash_clk),
    .flash_si       (flash_si)
  );

endmodule

// File: verification/spi_bridge_tb.sv
`timescale 1ns/1ps

module spi_bridge_tb import spi_bridge_pkg::*; ();

  localparam int HALF_SCK = 10;
  localparam int FLASH_HALF = 8;
  // bytes on the wire plus one per frame for chip select setup and hold
  localparam int BYTE_COUNT = 41;
  localparam int FLASH_XFERS = 1;
  localparam int TIMEOUT_CYCLES = BYTE_COUNT * 160 + FLASH_XFERS * 200;

  localparam byte_t EXP_COOKIE  = 8'haf;
  localparam byte_t EXP_VERSION = {3'd0, 5'd3};
  localparam byte_t DUMMY       = 8'h00;
  localparam byte_t BAD_OPCODE  = 8'h55;

  logic       clk;
  logic       cass_out_sel_n;
  logic       sck;
  logic       cs_n;
  logic       mosi;
  logic [3:0] conf;
  logic       flash_so;
  logic       miso;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic       led_err;
  logic       flash_cs_n;
  logic       flash_clk;
  logic       flash_si;

  int errors;
  int checks;
  int cycle_count;

  // flash model state
  byte_t      flash_reply;
  byte_t      flash_seen;
  bit_count_t flash_falls;
  int         flash_rises;

  spi_bridge_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reply goes out MSB first with one bit per falling flash clock
  assign flash_so = flash_reply[3'd7 - flash_falls];

  always @(negedge flash_clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n)
      flash_falls <= '0;
    else
      flash_falls <= flash_falls + 3'd1;
  end

  always @(posedge flash_clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      flash_seen  <= '0;
      flash_rises <= 0;
    end else begin
      flash_seen  <= {flash_seen[6:0], flash_si};
      flash_rises <= flash_rises + 1;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  function automatic byte_t rand_byte();
    logic [31:0] r;
    r = $urandom();
    return r[7:0];
  endfunction

  task automatic select_slave();
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (HALF_SCK - 1) @(posedge clk);
  endtask

  task automatic release_slave();
    repeat (HALF_SCK) @(posedge clk);
    cs_n <= 1'b1;
    repeat (HALF_SCK) @(posedge clk);
  endtask

  // mode 0 with miso read at the end of each low phase
  task automatic shift_byte(input byte_t tx, output byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      @(posedge clk);
      mosi <= tx[i];
      sck  <= 1'b0;
      repeat (HALF_SCK - 1) @(posedge clk);
      @(negedge clk);
      rx[i] = miso;
      @(posedge clk);
      sck <= 1'b1;
      repeat (HALF_SCK - 1) @(posedge clk);
    end
    @(posedge clk);
    sck <= 1'b0;
  endtask

  // opcode then one more byte whose reply is returned
  task automatic send_cmd(input opcode_t op, input byte_t second, output byte_t reply);
    byte_t unused;
    select_slave();
    shift_byte(op, unused);
    shift_byte(second, reply);
    release_slave();
  endtask

  task automatic after_reset();
    @(negedge clk);
    compare_bit("led_red", led_red, 1'b0);
    compare_bit("led_green", led_green, 1'b0);
    compare_bit("led_blue", led_blue, 1'b0);
    compare_bit("led_err", led_err, 1'b0);
    compare_bit("flash_cs_n", flash_cs_n, 1'b1);
    compare_bit("flash_clk", flash_clk, 1'b0);
    compare_bit("miso", miso, 1'b0);
  endtask

  task automatic identity_readback();
    byte_t reply;
    send_cmd(op_get_cookie, DUMMY, reply);
    compare_byte("miso cookie", reply, EXP_COOKIE);
    send_cmd(op_get_version, DUMMY, reply);
    compare_byte("miso version", reply, EXP_VERSION);
  endtask

  task automatic config_readback();
    byte_t      reply;
    byte_t      r;
    logic [3:0] sw;
    for (int n = 0; n < 4; n++) begin
      // odd passes flip every switch of the pass before
      if (n % 2 == 1) begin
        sw = ~sw;
      end else begin
        r  = rand_byte();
        sw = r[3:0];
      end
      @(posedge clk);
      conf <= sw;
      send_cmd(op_get_config, DUMMY, reply);
      // switches read back inverted
      compare_byte("miso config", reply, {4'b0000, ~sw});
    end
  endtask

  task automatic led_control();
    byte_t arg;
    byte_t reply;
    for (int n = 0; n < 3; n++) begin
      // second pass flips every led
      if (n == 1)
        arg = ~arg;
      else
        arg = rand_byte();
      send_cmd(op_set_led, arg, reply);
      @(negedge clk);
      compare_bit("led_red", led_red, arg[0]);
      compare_bit("led_green", led_green, arg[1]);
      compare_bit("led_blue", led_blue, arg[2]);
    end
  endtask

  task automatic wait_flash_done(input int start);
    while (flash_rises - start < 8)
      @(negedge clk);
    // last falling flash clock ends the transfer
    repeat (2 * FLASH_HALF) @(posedge clk);
  endtask

  task automatic flash_loop();
    byte_t ctrl;
    byte_t sent;
    byte_t answer;
    byte_t reply;
    int    start;
    ctrl = rand_byte() | 8'h80;
    send_cmd(op_set_spi_ctrl_reg, ctrl, reply);
    @(negedge clk);
    compare_bit("flash_cs_n", flash_cs_n, 1'b0);
    sent   = rand_byte();
    answer = rand_byte();
    @(posedge clk);
    flash_reply <= answer;
    start = flash_rises;
    send_cmd(op_set_spi_data, sent, reply);
    wait_flash_done(start);
    compare_byte("flash_si", flash_seen, sent);
    send_cmd(op_get_spi_data, DUMMY, reply);
    compare_byte("miso spi_data", reply, answer);
  endtask

  task automatic bad_opcode();
    byte_t reply;
    select_slave();
    shift_byte(BAD_OPCODE, reply);
    release_slave();
    @(negedge clk);
    compare_bit("led_err", led_err, 1'b1);
    send_cmd(op_get_cookie, DUMMY, reply);
    compare_byte("miso cookie", reply, EXP_COOKIE);
    @(negedge clk);
    compare_bit("led_err", led_err, 1'b1);
  endtask

  initial begin
    logic [31:0] seed_draw;
    errors = 0;
    checks = 0;
    seed_draw = $urandom(32'ha81e);
    cass_out_sel_n <= 1'b0;
    sck            <= 1'b0;
    cs_n           <= 1'b1;
    mosi           <= 1'b0;
    conf           <= 4'h0;
    flash_reply    <= 8'h00;
    repeat (5) @(posedge clk);
    cass_out_sel_n <= 1'b1;
    repeat (2) @(posedge clk);

    after_reset();
    identity_readback();
    config_readback();
    led_control();
    flash_loop();
    bad_opcode();

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: vlog.f
verilog/spi_bridge_pkg.sv
verilog/spi_slave.sv
verilog/cmd_parser.sv
verilog/ctrl_regs.sv
verilog/flash_spi_master.sv
verilog/spi_bridge_top.sv
verification/spi_bridge_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= spi_bridge_tb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
PASS_MSG   ?= *** TEST PASSED ***

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF -- "$(PASS_MSG)"; then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
